// File: project.f
+incdir+common
common/exe_pkg.sv
common/div_if.sv
logic/alu_core.sv
logic/hilo_unit.sv
logic/exe_ctrl.sv
divider/div_radix4.sv
logic/exe_stage.sv
verification/exe_checker.sv
verification/tb_exe_stage.sv

// File: Makefile
TOOL     := verilator
TOP      := tb_exe_stage
FILELIST := project.f
FLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage;
    import exe_pkg::*;

    localparam int          N_OPS      = 300;
    localparam int          MAX_CYCLES = N_OPS * 22 + 100;
    localparam logic [31:0] SEED       = 32'hbe83_1d4b;

    logic      cpu_clk_50M = 1'b0;
    logic      rst_n_i;
    alu_op_t   aluop_i;
    alu_type_t alutype_i;
    word_t     src1_i;
    word_t     src2_i;
    word_t     hi_i;
    word_t     lo_i;
    logic      mem_whilo_i;
    logic      wb_whilo_i;
    dword_t    mem_hilo_i;
    dword_t    wb_hilo_i;
    exc_code_t exccode_i;
    word_t     wd_o;
    dword_t    hilo_o;
    exc_code_t exccode_o;
    logic      stall_o;
    int        err_cnt;
    int        check_cnt;
    int        div_cnt;
    int        cycle_cnt = 0;

    exe_stage UUT (.*);

    exe_checker u_checker (
        .err_cnt_o   (err_cnt),
        .check_cnt_o (check_cnt),
        .div_cnt_o   (div_cnt),
        .*
    );

    always #10 cpu_clk_50M = ~cpu_clk_50M;

    function automatic alu_type_t type_of(input alu_op_t op);
        case (op)
            OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR, OP_LUI: return TYPE_LOGIC;
            OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV: return TYPE_SHIFT;
            OP_MFHI, OP_MFLO: return TYPE_MOVE;
            OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO, OP_DIV, OP_DIVU, OP_NOP: return TYPE_NOP;
            default: return TYPE_ARITH;
        endcase
    endfunction

    // corner values mixed in with plain random words
    function automatic word_t rand_word();
        case ($urandom % 8)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h7fff_ffff;
            4: return $urandom % 16;
            default: return $urandom;
        endcase
    endfunction

    function automatic alu_op_t pick_op();
        alu_op_t op;
        int      steps;
        if ($urandom % 5 == 0) begin
            return ($urandom % 2 == 0) ? OP_DIV : OP_DIVU;
        end
        op    = op.first();
        steps = $urandom % op.num();
        repeat (steps) op = op.next();
        if (op == OP_DIV || op == OP_DIVU) begin
            op = OP_NOP;
        end
        return op;
    endfunction

    task automatic drive_op();
        alu_op_t op;
        word_t   a;
        word_t   b;
        op = pick_op();
        a  = rand_word();
        b  = rand_word();
        // shift amounts of 0 and 31 show up often
        if (type_of(op) == TYPE_SHIFT) begin
            a = ($urandom % 3 == 0) ? 32'd0 : (($urandom % 2 == 0) ? 32'd31 : $urandom);
        end
        if ((op == OP_DIV || op == OP_DIVU) && ($urandom % 5 == 0)) begin
            b = '0;
        end
        aluop_i     <= op;
        alutype_i   <= type_of(op);
        src1_i      <= a;
        src2_i      <= b;
        hi_i        <= $urandom;
        lo_i        <= $urandom;
        mem_whilo_i <= 1'($urandom % 2);
        wb_whilo_i  <= 1'($urandom % 2);
        mem_hilo_i  <= {$urandom, $urandom};
        wb_hilo_i   <= {$urandom, $urandom};
        case ($urandom % 10)
            0: exccode_i <= EXC_OV;
            1: exccode_i <= EXC_DIV_ZERO;
            default: exccode_i <= EXC_NONE;
        endcase
    endtask

    task automatic print_counts();
        $display("checks %0d, divides %0d, errors %0d", check_cnt, div_cnt, err_cnt);
    endtask

    initial begin
        void'($urandom(SEED));
        // non-zero inputs so that forcing outputs to zero in reset is visible
        rst_n_i     <= 1'b0;
        aluop_i     <= OP_OR;
        alutype_i   <= TYPE_LOGIC;
        src1_i      <= 32'h1234_5678;
        src2_i      <= 32'h0f0f_0f0f;
        hi_i        <= 32'h1111_1111;
        lo_i        <= 32'h2222_2222;
        mem_whilo_i <= 1'b0;
        wb_whilo_i  <= 1'b0;
        mem_hilo_i  <= '0;
        wb_hilo_i   <= '0;
        exccode_i   <= EXC_OV;
        repeat (3) @(posedge cpu_clk_50M);
        // a hi/lo write and then a divide request, both held off by reset
        aluop_i <= OP_MTHI;
        repeat (3) @(posedge cpu_clk_50M);
        aluop_i <= OP_DIV;
        repeat (2) @(posedge cpu_clk_50M);
        rst_n_i <= 1'b1;
        for (int i = 0; i < N_OPS; i++) begin
            drive_op();
            // hold until a cycle without stall has been seen
            @(negedge cpu_clk_50M);
            while (stall_o) @(negedge cpu_clk_50M);
            @(posedge cpu_clk_50M);
        end
        aluop_i   <= OP_NOP;
        alutype_i <= TYPE_NOP;
        @(negedge cpu_clk_50M);
        @(posedge cpu_clk_50M);
        print_counts();
        if (err_cnt == 0 && check_cnt > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge cpu_clk_50M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// File: verification/exe_checker.sv
`timescale 1ns/1ps

module exe_checker (
    input  logic                cpu_clk_50M,
    input  logic                rst_n_i,
    input  exe_pkg::alu_op_t    aluop_i,
    input  exe_pkg::alu_type_t  alutype_i,
    input  exe_pkg::word_t      src1_i,
    input  exe_pkg::word_t      src2_i,
    input  exe_pkg::word_t      hi_i,
    input  exe_pkg::word_t      lo_i,
    input  logic                mem_whilo_i,
    input  logic                wb_whilo_i,
    input  exe_pkg::dword_t     mem_hilo_i,
    input  exe_pkg::dword_t     wb_hilo_i,
    input  exe_pkg::exc_code_t  exccode_i,
    input  exe_pkg::word_t      wd_o,
    input  exe_pkg::dword_t     hilo_o,
    input  exe_pkg::exc_code_t  exccode_o,
    input  logic                stall_o,
    output int                  err_cnt_o,
    output int                  check_cnt_o,
    output int                  div_cnt_o
);
    import exe_pkg::*;

    typedef struct packed {
        word_t     wd;
        dword_t    hilo;
        exc_code_t exc;
    } expect_t;

    int   err_cnt   = 0;
    int   check_cnt = 0;
    int   div_cnt   = 0;
    logic stall_q   = 1'b0;

    assign err_cnt_o   = err_cnt;
    assign check_cnt_o = check_cnt;
    assign div_cnt_o   = div_cnt;

    function automatic expect_t exe_model(
        input alu_op_t op, input alu_type_t ty, input word_t a, input word_t b,
        input word_t hi, input word_t lo, input logic mem_we, input dword_t mem_hl,
        input logic wb_we, input dword_t wb_hl, input exc_code_t exc_in
    );
        expect_t     e;
        word_t       alu;
        dword_t      fwd;
        logic [32:0] wide;
        logic [4:0]  sh;
        longint      q;
        longint      r;
        sh = a[4:0];
        case (op)
            OP_AND, OP_ANDI: alu = a & b;
            OP_OR, OP_ORI:   alu = a | b;
            OP_XOR, OP_XORI: alu = a ^ b;
            OP_NOR:          alu = ~(a | b);
            OP_LUI:          alu = b;
            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_LB, OP_LBU, OP_LH, OP_LHU,
            OP_LW, OP_SB, OP_SH, OP_SW: alu = a + b;
            OP_SUB, OP_SUBU:   alu = a - b;
            OP_SLT, OP_SLTI:   alu = word_t'($signed(a) < $signed(b));
            OP_SLTU, OP_SLTIU: alu = word_t'(a < b);
            OP_SLL, OP_SLLV:   alu = b << sh;
            OP_SRL, OP_SRLV:   alu = b >> sh;
            // sign fill from a double-width copy
            OP_SRA, OP_SRAV:   alu = word_t'({{32{b[31]}}, b} >> sh);
            default:           alu = '0;
        endcase
        // 33-bit result, overflow when the top two bits disagree
        wide = (op == OP_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
        fwd  = mem_we ? mem_hl : (wb_we ? wb_hl : {hi, lo});
        case (ty)
            TYPE_LOGIC, TYPE_ARITH, TYPE_SHIFT: e.wd = alu;
            TYPE_MOVE: e.wd = (op == OP_MFHI) ? fwd[63:32] : ((op == OP_MFLO) ? fwd[31:0] : '0);
            default:   e.wd = '0;
        endcase
        case (op)
            OP_MULT:  e.hilo = dword_t'(longint'($signed(a)) * longint'($signed(b)));
            OP_MULTU: e.hilo = {32'h0, a} * {32'h0, b};
            OP_MTHI:  e.hilo = {a, lo};
            OP_MTLO:  e.hilo = {hi, a};
            OP_DIV, OP_DIVU: begin
                if (b == '0) begin
                    e.hilo = '0;
                end else begin
                    q = (op == OP_DIV) ? longint'($signed(a)) : longint'({32'h0, a});
                    r = (op == OP_DIV) ? longint'($signed(b)) : longint'({32'h0, b});
                    e.hilo = {32'(q % r), 32'(q / r)};
                end
            end
            default:  e.hilo = '0;
        endcase
        if (exc_in != EXC_NONE) begin
            e.exc = exc_in;
        end else if ((op == OP_ADD || op == OP_ADDI || op == OP_SUB) &&
                     (wide[32] != wide[31])) begin
            e.exc = EXC_OV;
        end else if ((op == OP_DIV || op == OP_DIVU) && b == '0) begin
            e.exc = EXC_DIV_ZERO;
        end else begin
            e.exc = EXC_NONE;
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: expected %0h, got %0h (op %s)",
                     name, exp, got, aluop_i.name());
            err_cnt++;
        end
    endtask

    always @(negedge cpu_clk_50M) begin
        expect_t e;
        if (!rst_n_i) begin
            compare_value("wd_o", 64'(wd_o), '0);
            compare_value("hilo_o", hilo_o, '0);
            compare_value("exccode_o", 64'(exccode_o), '0);
            compare_value("stall_o", 64'(stall_o), '0);
        end else if (!stall_o) begin
            e = exe_model(aluop_i, alutype_i, src1_i, src2_i, hi_i, lo_i,
                          mem_whilo_i, mem_hilo_i, wb_whilo_i, wb_hilo_i, exccode_i);
            compare_value("wd_o", 64'(wd_o), 64'(e.wd));
            compare_value("hilo_o", hilo_o, e.hilo);
            compare_value("exccode_o", 64'(exccode_o), 64'(e.exc));
            check_cnt++;
            // a divide must have stalled before its result shows
            if (aluop_i == OP_DIV || aluop_i == OP_DIVU) begin
                if (stall_q) begin
                    div_cnt++;
                end else begin
                    $display("divide finished without raising stall_o first");
                    err_cnt++;
                end
            end
        end else if (aluop_i != OP_DIV && aluop_i != OP_DIVU) begin
            // only a divide may hold the pipeline
            compare_value("stall_o", 64'(stall_o), '0);
        end
        stall_q <= stall_o && rst_n_i;
    end

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                cpu_clk_50M,
    input  logic                rst_n_i,
    input  exe_pkg::alu_op_t    aluop_i,
    input  exe_pkg::alu_type_t  alutype_i,
    input  exe_pkg::word_t      src1_i,
    input  exe_pkg::word_t      src2_i,
    input  exe_pkg::word_t      hi_i,
    input  exe_pkg::word_t      lo_i,
    input  logic                mem_whilo_i,
    input  logic                wb_whilo_i,
    input  exe_pkg::dword_t     mem_hilo_i,
    input  exe_pkg::dword_t     wb_hilo_i,
    input  exe_pkg::exc_code_t  exccode_i,
    output exe_pkg::word_t      wd_o,
    output exe_pkg::dword_t     hilo_o,
    output exe_pkg::exc_code_t  exccode_o,
    output logic                stall_o
);
    import exe_pkg::*;

    word_t  alu_res;
    logic   alu_ov;
    word_t  move_res;
    dword_t hilo_res;

    div_if div_bus ();

    exe_ctrl u_exe_ctrl (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_n_i     (rst_n_i),
        .aluop_i     (aluop_i),
        .alutype_i   (alutype_i),
        .exccode_i   (exccode_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .alu_res_i   (alu_res),
        .alu_ov_i    (alu_ov),
        .move_res_i  (move_res),
        .hilo_res_i  (hilo_res),
        .wd_o        (wd_o),
        .hilo_o      (hilo_o),
        .exccode_o   (exccode_o),
        .stall_o     (stall_o),
        .div_bus     (div_bus.ctrl)
    );

    alu_core u_alu_core (
        .aluop_i (aluop_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .res_o   (alu_res),
        .ov_o    (alu_ov)
    );

    hilo_unit u_hilo_unit (
        .aluop_i     (aluop_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .hi_i        (hi_i),
        .lo_i        (lo_i),
        .mem_whilo_i (mem_whilo_i),
        .mem_hilo_i  (mem_hilo_i),
        .wb_whilo_i  (wb_whilo_i),
        .wb_hilo_i   (wb_hilo_i),
        .move_res_o  (move_res),
        .hilo_res_o  (hilo_res)
    );

    div_radix4 u_div_radix4 (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_n_i     (rst_n_i),
        .div_bus     (div_bus.div)
    );

endmodule

// File: divider/div_radix4.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module div_radix4 (
    input  logic cpu_clk_50M,
    input  logic rst_n_i,
    div_if.div   div_bus
);
    import exe_pkg::*;

    localparam int WORD_W = `EXE_WORD_W;
    localparam int QUO_W  = 2 * `EXE_DIV_STEPS;
    localparam int PART_W = WORD_W + 2;
    localparam logic [`EXE_DIV_CNT_W-1:0] LAST_STEP = `EXE_DIV_STEPS;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ZERO,
        DIV_RUN,
        DIV_END
    } div_state_t;

    div_state_t                state;
    logic [`EXE_DIV_CNT_W-1:0] cnt;
    word_t                     rem;
    logic [QUO_W-1:0]          quo;
    word_t                     dsr;
    logic                      neg_quo;
    logic                      neg_rem;
    word_t                     abs_dividend;
    word_t                     abs_divisor;
    logic [PART_W-1:0]         part;
    logic [PART_W-1:0]         dsr_x1;
    logic [PART_W-1:0]         dsr_x2;
    logic [PART_W-1:0]         dsr_x3;
    logic [PART_W:0]           diff1;
    logic [PART_W:0]           diff2;
    logic [PART_W:0]           diff3;
    word_t                     rem_next;
    logic [1:0]                qbits;

    assign abs_dividend = (div_bus.is_signed && div_bus.dividend[WORD_W-1]) ?
                          -div_bus.dividend : div_bus.dividend;
    assign abs_divisor  = (div_bus.is_signed && div_bus.divisor[WORD_W-1]) ?
                          -div_bus.divisor : div_bus.divisor;

    // partial remainder with the next two dividend bits
    assign part   = {rem, quo[QUO_W-1 -: 2]};
    assign dsr_x1 = {2'b00, dsr};
    assign dsr_x2 = {1'b0, dsr, 1'b0};
    assign dsr_x3 = dsr_x1 + dsr_x2;
    assign diff1  = {1'b0, part} - {1'b0, dsr_x1};
    assign diff2  = {1'b0, part} - {1'b0, dsr_x2};
    assign diff3  = {1'b0, part} - {1'b0, dsr_x3};

    // largest multiple that still fits
    always_comb begin
        if (!diff3[PART_W]) begin
            qbits    = 2'd3;
            rem_next = diff3[WORD_W-1:0];
        end else if (!diff2[PART_W]) begin
            qbits    = 2'd2;
            rem_next = diff2[WORD_W-1:0];
        end else if (!diff1[PART_W]) begin
            qbits    = 2'd1;
            rem_next = diff1[WORD_W-1:0];
        end else begin
            qbits    = 2'd0;
            rem_next = part[WORD_W-1:0];
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (!rst_n_i) begin
            state          <= DIV_IDLE;
            cnt            <= '0;
            div_bus.ready  <= 1'b0;
            div_bus.result <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    div_bus.ready  <= 1'b0;
                    div_bus.result <= '0;
                    if (div_bus.start) begin
                        cnt   <= '0;
                        state <= (div_bus.divisor == '0) ? DIV_ZERO : DIV_RUN;
                    end
                end
                DIV_ZERO: state <= DIV_END;
                DIV_RUN: begin
                    // the step after the last iteration fixes signs
                    if (cnt != LAST_STEP) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        state <= DIV_END;
                    end
                end
                DIV_END: begin
                    if (!div_bus.start) begin
                        state          <= DIV_IDLE;
                        div_bus.ready  <= 1'b0;
                        div_bus.result <= '0;
                    end else begin
                        div_bus.ready  <= 1'b1;
                        div_bus.result <= {rem, quo[WORD_W-1:0]};
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        case (state)
            DIV_IDLE: begin
                if (div_bus.start) begin
                    rem     <= '0;
                    quo     <= {{(QUO_W-WORD_W){1'b0}}, abs_dividend};
                    dsr     <= abs_divisor;
                    neg_quo <= div_bus.is_signed &&
                               (div_bus.dividend[WORD_W-1] ^ div_bus.divisor[WORD_W-1]);
                    neg_rem <= div_bus.is_signed && div_bus.dividend[WORD_W-1];
                end
            end
            DIV_ZERO: begin
                rem <= '0;
                quo <= '0;
            end
            DIV_RUN: begin
                if (cnt != LAST_STEP) begin
                    rem <= rem_next;
                    quo <= {quo[QUO_W-3:0], qbits};
                end else begin
                    if (neg_quo) begin
                        quo[WORD_W-1:0] <= -quo[WORD_W-1:0];
                    end
                    // remainder follows the dividend sign
                    if (neg_rem) begin
                        rem <= -rem;
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/exe_ctrl.sv
`timescale 1ns/1ps

module exe_ctrl (
    input  logic                cpu_clk_50M,
    input  logic                rst_n_i,
    input  exe_pkg::alu_op_t    aluop_i,
    input  exe_pkg::alu_type_t  alutype_i,
    input  exe_pkg::exc_code_t  exccode_i,
    input  exe_pkg::word_t      src1_i,
    input  exe_pkg::word_t      src2_i,
    input  exe_pkg::word_t      alu_res_i,
    input  logic                alu_ov_i,
    input  exe_pkg::word_t      move_res_i,
    input  exe_pkg::dword_t     hilo_res_i,
    output exe_pkg::word_t      wd_o,
    output exe_pkg::dword_t     hilo_o,
    output exe_pkg::exc_code_t  exccode_o,
    output logic                stall_o,
    div_if.ctrl                 div_bus
);
    import exe_pkg::*;

    logic  is_div;
    logic  ov_op;
    logic  div_busy_q;
    logic  signed_q;
    word_t op1_q;
    word_t op2_q;

    assign is_div = (aluop_i == OP_DIV) || (aluop_i == OP_DIVU);
    assign ov_op  = (aluop_i == OP_ADD) || (aluop_i == OP_ADDI) || (aluop_i == OP_SUB);

    // start stays up until the divider reports ready
    assign div_bus.start = is_div && !div_bus.ready;

    // operands frozen for the rest of a running divide
    assign div_bus.dividend  = div_busy_q ? op1_q : src1_i;
    assign div_bus.divisor   = div_busy_q ? op2_q : src2_i;
    assign div_bus.is_signed = div_busy_q ? signed_q : (aluop_i == OP_DIV);

    always_ff @(posedge cpu_clk_50M) begin
        if (!rst_n_i) begin
            div_busy_q <= 1'b0;
        end else begin
            div_busy_q <= div_bus.start;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (div_bus.start && !div_busy_q) begin
            op1_q    <= src1_i;
            op2_q    <= src2_i;
            signed_q <= (aluop_i == OP_DIV);
        end
    end

    always_comb begin
        if (!rst_n_i) begin
            wd_o      = '0;
            hilo_o    = '0;
            exccode_o = EXC_NONE;
            stall_o   = 1'b0;
        end else begin
            stall_o = div_bus.start;
            case (alutype_i)
                TYPE_LOGIC, TYPE_ARITH, TYPE_SHIFT: wd_o = alu_res_i;
                TYPE_MOVE:                          wd_o = move_res_i;
                default:                            wd_o = '0;
            endcase
            hilo_o = is_div ? div_bus.result : hilo_res_i;
            // earlier stage exceptions take priority
            if (exccode_i != EXC_NONE) begin
                exccode_o = exccode_i;
            end else if (ov_op && alu_ov_i) begin
                exccode_o = EXC_OV;
            end else if (is_div && (div_bus.divisor == '0)) begin
                exccode_o = EXC_DIV_ZERO;
            end else begin
                exccode_o = EXC_NONE;
            end
        end
    end

endmodule

// File: logic/hilo_unit.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module hilo_unit (
    input  exe_pkg::alu_op_t aluop_i,
    input  exe_pkg::word_t   src1_i,
    input  exe_pkg::word_t   src2_i,
    input  exe_pkg::word_t   hi_i,
    input  exe_pkg::word_t   lo_i,
    input  logic             mem_whilo_i,
    input  exe_pkg::dword_t  mem_hilo_i,
    input  logic             wb_whilo_i,
    input  exe_pkg::dword_t  wb_hilo_i,
    output exe_pkg::word_t   move_res_o,
    output exe_pkg::dword_t  hilo_res_o
);
    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;

    dword_t               hilo_fwd;
    logic                 mul_signed;
    logic signed [W:0]    mul_a;
    logic signed [W:0]    mul_b;
    logic signed [2*W+1:0] mul_p;

    // newest write wins
    assign hilo_fwd = mem_whilo_i ? mem_hilo_i :
                      wb_whilo_i  ? wb_hilo_i  : {hi_i, lo_i};

    assign move_res_o = (aluop_i == OP_MFHI) ? hilo_fwd[2*W-1:W] :
                        (aluop_i == OP_MFLO) ? hilo_fwd[W-1:0]   : '0;

    // one 33x33 signed multiplier for both mult flavours
    assign mul_signed = (aluop_i == OP_MULT);
    assign mul_a = {mul_signed & src1_i[W-1], src1_i};
    assign mul_b = {mul_signed & src2_i[W-1], src2_i};
    assign mul_p = mul_a * mul_b;

    always_comb begin
        case (aluop_i)
            OP_MULT, OP_MULTU: hilo_res_o = mul_p[2*W-1:0];
            OP_MTHI:           hilo_res_o = {src1_i, lo_i};
            OP_MTLO:           hilo_res_o = {hi_i, src1_i};
            default:           hilo_res_o = '0;
        endcase
    end

endmodule

// File: logic/alu_core.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module alu_core (
    input  exe_pkg::alu_op_t aluop_i,
    input  exe_pkg::word_t   src1_i,
    input  exe_pkg::word_t   src2_i,
    output exe_pkg::word_t   res_o,
    output logic             ov_o
);
    import exe_pkg::*;

    localparam int MSB     = `EXE_WORD_W - 1;
    localparam int SHAMT_W = $clog2(`EXE_WORD_W);

    word_t              sum;
    word_t              diff;
    logic [SHAMT_W-1:0] shamt;
    logic               add_ov;
    logic               sub_ov;

    assign sum   = src1_i + src2_i;
    assign diff  = src1_i - src2_i;
    // shift amount always from the low bits of src1
    assign shamt = src1_i[SHAMT_W-1:0];

    // same-sign operands giving a flipped sign
    assign add_ov = (src1_i[MSB] == src2_i[MSB]) && (sum[MSB] != src1_i[MSB]);
    assign sub_ov = (src1_i[MSB] != src2_i[MSB]) && (diff[MSB] != src1_i[MSB]);

    assign ov_o = ((aluop_i == OP_SUB) || (aluop_i == OP_SUBU)) ? sub_ov : add_ov;

    always_comb begin
        case (aluop_i)
            OP_AND, OP_ANDI: res_o = src1_i & src2_i;
            OP_OR, OP_ORI:   res_o = src1_i | src2_i;
            OP_XOR, OP_XORI: res_o = src1_i ^ src2_i;
            OP_NOR:          res_o = ~(src1_i | src2_i);
            OP_LUI:          res_o = src2_i;

            // address adds share the adder
            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW: res_o = sum;
            OP_SUB, OP_SUBU:     res_o = diff;

            OP_SLT, OP_SLTI: begin
                res_o = {{MSB{1'b0}}, ($signed(src1_i) < $signed(src2_i))};
            end
            OP_SLTU, OP_SLTIU: begin
                res_o = {{MSB{1'b0}}, (src1_i < src2_i)};
            end

            OP_SLL, OP_SLLV: res_o = src2_i << shamt;
            OP_SRL, OP_SRLV: res_o = src2_i >> shamt;
            OP_SRA, OP_SRAV: res_o = word_t'($signed(src2_i) >>> shamt);

            default: res_o = '0;
        endcase
    end

endmodule

// File: common/div_if.sv
`timescale 1ns/1ps

interface div_if;
    import exe_pkg::*;

    logic   start;
    logic   is_signed;
    word_t  dividend;
    word_t  divisor;
    logic   ready;
    // remainder in hi, quotient in lo
    dword_t result;

    modport ctrl (
        output start, is_signed, dividend, divisor,
        input  ready, result
    );

    modport div (
        input  start, is_signed, dividend, divisor,
        output ready, result
    );

endinterface

// File: common/exe_pkg.sv
`include "exe_defs.svh"

package exe_pkg;

    typedef logic [`EXE_WORD_W-1:0]  word_t;
    // hi in the upper half
    typedef logic [`EXE_DWORD_W-1:0] dword_t;

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_AND   = 8'h01, OP_ANDI  = 8'h02, OP_OR    = 8'h03, OP_ORI   = 8'h04,
        OP_XOR   = 8'h05, OP_XORI  = 8'h06, OP_NOR   = 8'h07, OP_LUI   = 8'h08,
        OP_ADD   = 8'h10, OP_ADDI  = 8'h11, OP_ADDU  = 8'h12, OP_ADDIU = 8'h13,
        OP_SUB   = 8'h14, OP_SUBU  = 8'h15,
        OP_SLT   = 8'h16, OP_SLTI  = 8'h17, OP_SLTU  = 8'h18, OP_SLTIU = 8'h19,
        OP_LB    = 8'h20, OP_LBU   = 8'h21, OP_LH    = 8'h22, OP_LHU   = 8'h23,
        OP_LW    = 8'h24, OP_SB    = 8'h25, OP_SH    = 8'h26, OP_SW    = 8'h27,
        OP_SLL   = 8'h30, OP_SLLV  = 8'h31, OP_SRL   = 8'h32, OP_SRLV  = 8'h33,
        OP_SRA   = 8'h34, OP_SRAV  = 8'h35,
        OP_MULT  = 8'h40, OP_MULTU = 8'h41, OP_MTHI  = 8'h42, OP_MTLO  = 8'h43,
        OP_MFHI  = 8'h44, OP_MFLO  = 8'h45, OP_DIV   = 8'h46, OP_DIVU  = 8'h47
    } alu_op_t;

    // result class, picks which value lands in wd
    typedef enum logic [2:0] {
        TYPE_NOP   = 3'd0,
        TYPE_LOGIC = 3'd1,
        TYPE_ARITH = 3'd2,
        TYPE_SHIFT = 3'd3,
        TYPE_MOVE  = 3'd4
    } alu_type_t;

    typedef enum logic [4:0] {
        EXC_NONE     = 5'h00,
        EXC_OV       = 5'h0c,
        EXC_DIV_ZERO = 5'h0d
    } exc_code_t;

endpackage

// File: common/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// data word and the hi/lo pair
`define EXE_WORD_W      32
`define EXE_DWORD_W     64

// radix-4 divider, two quotient bits per step
`define EXE_DIV_STEPS   17

// wide enough to count up to EXE_DIV_STEPS
`define EXE_DIV_CNT_W   5

`endif
